//--- testbench/memory_stimulus.txt
# kind we byte_m addr wdata expected, numbers after kind/we/byte_m in hex
# kind 1 compares rd_data with expected, kind 0 only waits for ready
1 0 0 c0000 0000 5a5a
1 0 0 c0002 0000 c46d
1 0 0 f0000 0000 da5a
1 0 0 f0002 0000 446d
1 0 0 ffffe 0000 3b93
1 0 1 c0001 0000 005a
1 0 1 c0002 0000 006d
1 0 0 c0001 0000 6d5a
1 0 0 c0003 0000 34c4
1 0 0 f0001 0000 6dda
0 1 0 f0002 ffff 0000
1 0 0 f0002 0000 446d
0 1 1 c0001 0012 0000
1 0 0 c0000 0000 5a5a
0 1 0 01000 1234 0000
1 0 0 01000 0000 1234
0 1 1 01001 00ab 0000
1 0 0 01000 0000 ab34
0 1 1 01002 00cd 0000
1 0 0 01002 0000 00cd
0 1 0 01005 beef 0000
1 0 0 01004 0000 ef00
1 0 0 01006 0000 00be
1 0 0 01005 0000 beef
1 0 1 01003 0000 0000

//--- verilog.f
verilog/mem_pkg.sv
verilog/flash_rom_cntrlr.sv
verilog/sram_cntrlr.sv
verilog/memory.sv
testbench/ext_mem_models.sv
testbench/memory_sva.sv
testbench/memory_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= memory_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it into $(LOG), check the verdict"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
	  --Mdir $(BUILD_DIR) -f $(FILELIST) $(VFLAGS)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF -- '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/memory_tb.sv
`timescale 1ns/1ps

module memory_tb;

  import mem_pkg::*;

  localparam int    FLASH_WAIT = 3;
  localparam int    SRAM_WAIT  = 2;
  localparam int    N_RANDOM   = 200;
  localparam string STIM_FILE  = "testbench/memory_stimulus.txt";

  typedef struct packed {
    logic  check;    // compare rd_data with exp
    logic  we;
    logic  byte_m;
    addr_t addr;
    data_t wr_data;
    data_t exp;
  } op_t;

  logic        cpu_clk = 1'b0;
  logic        rst;
  addr_t       addr;
  data_t       wr_data;
  logic        we;
  logic        byte_m;
  logic        mem_op;
  data_t       rd_data;
  logic        ready;
  logic        nf_we;
  logic        nf_ce;
  logic        nf_oe;
  logic        nf_byte;
  flash_addr_t nf_a;
  data_t       nf_d;
  word_addr_t  sram_a;
  wire [15:0]  sram_dq;
  logic        sram_ce_n;
  logic        sram_oe_n;
  logic        sram_we_n;
  logic        sram_ub_n;
  logic        sram_lb_n;

  op_t         ops[$];
  logic [7:0]  shadow [0:(1<<20)-1];
  int          checks = 0;
  int          read_errs = 0;
  int          other_errs = 0;
  int          limit_cycles = 0;
  logic [31:0] rng = 32'hf4bf_7647;

  always #5 cpu_clk = ~cpu_clk;

  memory #(.FLASH_WAIT(FLASH_WAIT), .SRAM_WAIT(SRAM_WAIT)) memory_i (
    .cpu_clk (cpu_clk), .rst (rst), .addr (addr), .wr_data (wr_data), .we (we),
    .byte_m (byte_m), .rd_data (rd_data), .mem_op (mem_op), .ready (ready),
    .nf_we (nf_we), .nf_ce (nf_ce), .nf_oe (nf_oe), .nf_byte (nf_byte), .nf_a (nf_a),
    .nf_d (nf_d), .sram_a (sram_a), .sram_dq (sram_dq), .sram_ce_n (sram_ce_n),
    .sram_oe_n (sram_oe_n), .sram_we_n (sram_we_n), .sram_ub_n (sram_ub_n),
    .sram_lb_n (sram_lb_n)
  );

  nor_flash flash_i (.a (nf_a), .ce_n (nf_ce), .oe_n (nf_oe), .d (nf_d));

  async_sram sram_i (
    .clk (cpu_clk), .a (sram_a), .dq (sram_dq), .ce_n (sram_ce_n), .oe_n (sram_oe_n),
    .we_n (sram_we_n), .ub_n (sram_ub_n), .lb_n (sram_lb_n)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic is_rom(input addr_t a);
    return (a[19:16] == 4'hf) || (a[19:16] == 4'hc);  // bios and video bios
  endfunction

  // cycles from driving mem_op to seeing ready
  function automatic int latency(input logic w, input logic b, input addr_t a);
    int n;
    n = is_rom(a) ? FLASH_WAIT : SRAM_WAIT;
    if (is_rom(a) && w)
      return 1;
    if (a[0] && !b)
      return 2 * n + 2;
    return n + 1;
  endfunction

  task automatic shadow_write(input addr_t a, input data_t d, input logic b);
    shadow[a] = d[7:0];
    if (!b)
      shadow[a + 20'd1] = d[15:8];
  endtask

  task automatic check_read(input addr_t a, input data_t got, input data_t exp);
    checks++;
    assert (got == exp) else begin
      read_errs++;
      $display("FAILED %0t: read %05h returned %04h, expected %04h", $time, a, got, exp);
    end
  endtask

  task automatic check_idle_pins();
    logic [9:0] pins;
    pins = {ready, nf_ce, nf_oe, nf_we, nf_byte, sram_ce_n, sram_oe_n, sram_we_n,
            sram_ub_n, sram_lb_n};
    checks++;
    assert (pins == 10'b01_1111_1111) else begin
      other_errs++;
      $display("FAILED %0t: pins after reset %010b, expected 0111111111", $time, pins);
    end
  endtask

  task automatic access(input op_t op, output data_t rd);
    int cycles;
    cycles = 0;
    @(posedge cpu_clk);
    #1;
    addr    = op.addr;
    wr_data = op.wr_data;
    we      = op.we;
    byte_m  = op.byte_m;
    mem_op  = 1'b1;
    do begin
      @(posedge cpu_clk);
      #1;
      cycles++;
    end while (!ready);
    rd     = rd_data;
    mem_op = 1'b0;
    checks++;
    assert (cycles == latency(op.we, op.byte_m, op.addr)) else begin
      other_errs++;
      $display("FAILED %0t: ready at %05h after %0d cycles, expected %0d", $time,
               op.addr, cycles, latency(op.we, op.byte_m, op.addr));
    end
  endtask

  initial begin : main
    int          fd;
    int          n;
    int          k;
    int          w;
    int          b;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    string       line;
    data_t       rd;
    addr_t       ra;
    op_t         op;

    rst     = 1'b1;
    addr    = '0;
    wr_data = '0;
    we      = 1'b0;
    byte_m  = 1'b0;
    mem_op  = 1'b0;
    for (int i = 0; i < (1 << 20); i++)
      shadow[20'(i)] = 8'h00;

    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      other_errs++;
      $display("could not open %s, directed tests skipped", STIM_FILE);
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%d %d %d %h %h %h", k, w, b, a, d, e);
        if (n == 6)   // comment lines fail the scan
          ops.push_back('{check: k[0], we: w[0], byte_m: b[0], addr: a[19:0],
                          wr_data: d[15:0], exp: e[15:0]});
      end
      $fclose(fd);
    end
    limit_cycles = (ops.size() + N_RANDOM) * 40;

    repeat (2) @(posedge cpu_clk);
    #1;
    rst = 1'b0;
    check_idle_pins();

    foreach (ops[i]) begin
      access(ops[i], rd);
      if (ops[i].check)
        check_read(ops[i].addr, rd, ops[i].exp);
      if (ops[i].we && !is_rom(ops[i].addr))
        shadow_write(ops[i].addr, ops[i].wr_data, ops[i].byte_m);
    end

    repeat (N_RANDOM) begin
      rng = xorshift32(rng);
      ra  = rng[19:0];
      if (is_rom(ra))
        ra[18] = 1'b0;  // C -> 8, F -> B
      op.addr   = ra;
      op.we     = rng[20];
      op.byte_m = rng[21];
      op.check  = !rng[20];
      rng = xorshift32(rng);
      op.wr_data = rng[15:0];
      op.exp = op.byte_m ? {8'h00, shadow[ra]} : {shadow[ra + 20'd1], shadow[ra]};
      access(op, rd);
      if (op.we)
        shadow_write(ra, op.wr_data, op.byte_m);
      else
        check_read(ra, rd, op.exp);
    end

    $display("checks %0d, read errors %0d, other errors %0d", checks, read_errs,
             other_errs);
    if (read_errs + other_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin : watchdog
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge cpu_clk);
    $display("timeout: run did not finish within %0d cycles", limit_cycles);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- testbench/memory_sva.sv
`timescale 1ns/1ps

module memory_sva (
  input logic cpu_clk,
  input logic rst,
  input logic mem_op,
  input logic ready,
  input logic nf_ce,
  input logic sram_ce_n
);

  logic op_seen;  // mem_op high at least once since reset

  always_ff @(posedge cpu_clk) begin
    if (rst)
      op_seen <= 1'b0;
    else if (mem_op)
      op_seen <= 1'b1;
  end

  ready_single: assert property (@(posedge cpu_clk) disable iff (rst) ready |=> !ready)
    else $error("ready high for two cycles in a row");

  one_device: assert property (@(posedge cpu_clk) disable iff (rst) !(!nf_ce && !sram_ce_n))
    else $error("flash and sram chip enables low together");

  no_early_ready: assert property (@(posedge cpu_clk) disable iff (rst) ready |-> op_seen)
    else $error("ready raised before any mem_op since reset");

endmodule

bind memory memory_sva sva_i (
  .cpu_clk   (cpu_clk),
  .rst       (rst),
  .mem_op    (mem_op),
  .ready     (ready),
  .nf_ce     (nf_ce),
  .sram_ce_n (sram_ce_n)
);

//--- testbench/ext_mem_models.sv
`timescale 1ns/1ps

// word-mode nor flash with contents patterned on the word index
module nor_flash (
  input  mem_pkg::flash_addr_t a,
  input  logic                 ce_n,
  input  logic                 oe_n,
  output mem_pkg::data_t       d
);

  import mem_pkg::*;

  data_t prod;

  assign prod = data_t'(a) * 16'h9e37;
  assign d    = (!ce_n && !oe_n) ? (prod ^ 16'h5a5a) : 16'hffff;

endmodule

module async_sram (
  input  logic                clk,    // only used to sample the write strobe
  input  mem_pkg::word_addr_t a,
  inout  wire mem_pkg::data_t dq,
  input  logic                ce_n,
  input  logic                oe_n,
  input  logic                we_n,
  input  logic                ub_n,
  input  logic                lb_n
);

  import mem_pkg::*;

  data_t mem [0:(1<<19)-1];

  initial begin
    for (int i = 0; i < (1 << 19); i++)
      mem[19'(i)] = '0;
  end

  always @(posedge clk) begin
    if (!ce_n && !we_n) begin
      if (!lb_n)
        mem[a][7:0] = dq[7:0];
      if (!ub_n)
        mem[a][15:8] = dq[15:8];
    end
  end

  assign dq = (!ce_n && !oe_n && we_n) ? mem[a] : 'z;

endmodule

//--- verilog/memory.sv
`timescale 1ns/1ps

module memory #(
  parameter int unsigned FLASH_WAIT = 3,
  parameter int unsigned SRAM_WAIT  = 2
) (
  input  logic                 cpu_clk,
  input  logic                 rst,

  // cpu side
  input  mem_pkg::addr_t       addr,
  input  mem_pkg::data_t       wr_data,
  input  logic                 we,
  input  logic                 byte_m,
  output mem_pkg::data_t       rd_data,
  input  logic                 mem_op,
  output logic                 ready,

  // nor flash
  output logic                 nf_we,
  output logic                 nf_ce,
  output logic                 nf_oe,
  output logic                 nf_byte,
  output mem_pkg::flash_addr_t nf_a,
  input  mem_pkg::data_t       nf_d,

  // async sram
  output mem_pkg::word_addr_t  sram_a,
  inout  wire mem_pkg::data_t  sram_dq,
  output logic                 sram_ce_n,
  output logic                 sram_oe_n,
  output logic                 sram_we_n,
  output logic                 sram_ub_n,
  output logic                 sram_lb_n
);

  import mem_pkg::*;

  mem_req_t  req;
  logic      rom_area;
  rom_addr_t rom_addr;
  logic      rom_op;
  logic      ram_op;
  data_t     rd_rom_data;
  data_t     rd_ram_data;
  logic      rom_ready;
  logic      ram_ready;
  logic      rom_wr;
  logic      rom_wr_done;
  logic      rom_wr_armed;

  assign req = '{addr: addr, wr_data: wr_data, we: we, byte_m: byte_m};

  assign rom_area = (addr[19:16] == ROM_SEG_BIOS) || (addr[19:16] == ROM_SEG_VGA);
  assign rom_addr = {addr[19:16] == ROM_SEG_BIOS, addr[15:0]};  // F is upper half
  assign rom_wr   = rom_area && we && mem_op;
  assign rom_op   = rom_area && !we && mem_op;   // flash never sees writes
  assign ram_op   = !rom_area && mem_op;

  // writes to rom are dropped but still answered next cycle
  always_ff @(posedge cpu_clk) begin
    if (rst) begin
      rom_wr_done  <= 1'b0;
      rom_wr_armed <= 1'b1;
    end else begin
      rom_wr_done <= rom_wr && rom_wr_armed;
      if (rom_wr && rom_wr_armed)
        rom_wr_armed <= 1'b0;
      else if (!mem_op)
        rom_wr_armed <= 1'b1;
    end
  end

  flash_rom_cntrlr #(.FLASH_WAIT(FLASH_WAIT)) flash0 (
    .cpu_clk  (cpu_clk),
    .rst      (rst),
    .rom_addr (rom_addr),
    .byte_m   (byte_m),
    .enable   (rom_op),
    .rd_data  (rd_rom_data),
    .ready    (rom_ready),
    .nf_we    (nf_we),
    .nf_ce    (nf_ce),
    .nf_oe    (nf_oe),
    .nf_byte  (nf_byte),
    .nf_a     (nf_a),
    .nf_d     (nf_d)
  );

  sram_cntrlr #(.SRAM_WAIT(SRAM_WAIT)) sram0 (
    .cpu_clk   (cpu_clk),
    .rst       (rst),
    .req       (req),
    .enable    (ram_op),
    .rd_data   (rd_ram_data),
    .ready     (ram_ready),
    .sram_a    (sram_a),
    .sram_dq   (sram_dq),
    .sram_ce_n (sram_ce_n),
    .sram_oe_n (sram_oe_n),
    .sram_we_n (sram_we_n),
    .sram_ub_n (sram_ub_n),
    .sram_lb_n (sram_lb_n)
  );

  assign rd_data = rom_area ? rd_rom_data : rd_ram_data;
  assign ready   = rom_area ? (rom_ready || rom_wr_done) : ram_ready;

endmodule

//--- verilog/sram_cntrlr.sv
`timescale 1ns/1ps

module sram_cntrlr #(
  parameter int unsigned SRAM_WAIT = 2
) (
  input  logic                cpu_clk,
  input  logic                rst,

  input  mem_pkg::mem_req_t   req,
  input  logic                enable,
  output mem_pkg::data_t      rd_data,
  output logic                ready,

  output mem_pkg::word_addr_t sram_a,
  inout  wire mem_pkg::data_t sram_dq,
  output logic                sram_ce_n,
  output logic                sram_oe_n,
  output logic                sram_we_n,
  output logic                sram_ub_n,
  output logic                sram_lb_n
);

  import mem_pkg::*;

  localparam int CW = $clog2(SRAM_WAIT + 1);

  bus_state_t    state;
  logic [CW-1:0] cnt;
  logic          armed;

  word_addr_t    word_q;
  data_t         wr_q;
  logic          odd_q;
  logic          byte_q;
  logic          we_q;

  logic          start;
  logic          last;
  logic          split;
  logic          active;
  logic          lo_en;
  logic          hi_en;
  data_t         dq_out;

  assign start = (state == IDLE) && enable && armed;
  assign last  = (cnt == '0);
  assign split = odd_q && !byte_q;

  // HIGH_CYCLE opens with a strobe-free tick so we_n can rise between the halves
  assign active = (state == LOW_CYCLE) ||
                  (state == HIGH_CYCLE && cnt != CW'(SRAM_WAIT));

  always_ff @(posedge cpu_clk) begin
    if (rst) begin
      state <= IDLE;
      cnt   <= '0;
      armed <= 1'b1;
    end else begin
      if (!enable)
        armed <= 1'b1;
      case (state)
        IDLE: begin
          if (start) begin
            state <= LOW_CYCLE;
            cnt   <= CW'(SRAM_WAIT - 1);
            armed <= 1'b0;
          end
        end
        LOW_CYCLE: begin
          if (last) begin
            state <= split ? HIGH_CYCLE : DONE;
            cnt   <= CW'(SRAM_WAIT);
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        HIGH_CYCLE: begin
          if (last)
            state <= DONE;
          else
            cnt <= cnt - 1'b1;
        end
        DONE:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge cpu_clk) begin
    if (start) begin
      word_q <= req.addr[19:1];
      odd_q  <= req.addr[0];
      byte_q <= req.byte_m;
      we_q   <= req.we;
      wr_q   <= req.wr_data;
    end else if (state == LOW_CYCLE && last) begin
      if (split)
        word_q <= word_q + 1'b1;
      if (!we_q) begin
        if (byte_q)
          rd_data <= {8'h00, odd_q ? sram_dq[15:8] : sram_dq[7:0]};
        else if (odd_q)
          rd_data[7:0] <= sram_dq[15:8];
        else
          rd_data <= sram_dq;
      end
    end else if (state == HIGH_CYCLE && last && !we_q) begin
      rd_data[15:8] <= sram_dq[7:0];
    end
  end

  // lane selection
  always_comb begin
    if (state == HIGH_CYCLE) begin
      lo_en = 1'b1;              // second half of unaligned word
      hi_en = 1'b0;
    end else begin
      lo_en = !odd_q;
      hi_en = odd_q || !byte_q;
    end
  end

  // low byte goes to the upper lane on odd addresses
  assign dq_out = (state == HIGH_CYCLE) ? {2{wr_q[15:8]}} :
                  odd_q                 ? {2{wr_q[7:0]}}  : wr_q;

  assign sram_dq   = (active && we_q) ? dq_out : 'z;
  assign sram_a    = word_q;
  assign sram_ce_n = !active;
  assign sram_oe_n = !(active && !we_q);
  assign sram_we_n = !(active && we_q);
  assign sram_ub_n = !(active && hi_en);
  assign sram_lb_n = !(active && lo_en);
  assign ready     = (state == DONE);

endmodule

//--- verilog/flash_rom_cntrlr.sv
`timescale 1ns/1ps

module flash_rom_cntrlr #(
  parameter int unsigned FLASH_WAIT = 3
) (
  input  logic                 cpu_clk,
  input  logic                 rst,

  input  mem_pkg::rom_addr_t   rom_addr,
  input  logic                 byte_m,
  input  logic                 enable,
  output mem_pkg::data_t       rd_data,
  output logic                 ready,

  output logic                 nf_we,
  output logic                 nf_ce,
  output logic                 nf_oe,
  output logic                 nf_byte,
  output mem_pkg::flash_addr_t nf_a,
  input  mem_pkg::data_t       nf_d
);

  import mem_pkg::*;

  localparam int CW = $clog2(FLASH_WAIT + 1);

  bus_state_t   state;
  logic [CW-1:0] cnt;
  logic         armed;      // op seen low since last access

  logic [15:0]  word_q;     // word index inside the image
  logic         odd_q;
  logic         byte_q;

  logic         start;
  logic         last;
  logic         split;
  logic         active;

  assign start = (state == IDLE) && enable && armed;
  assign last  = (cnt == '0);
  assign split = odd_q && !byte_q;   // unaligned word

  // first HIGH_CYCLE tick is a gap with the strobes off
  assign active = (state == LOW_CYCLE) ||
                  (state == HIGH_CYCLE && cnt != CW'(FLASH_WAIT));

  always_ff @(posedge cpu_clk) begin
    if (rst) begin
      state <= IDLE;
      cnt   <= '0;
      armed <= 1'b1;
    end else begin
      if (!enable)
        armed <= 1'b1;
      case (state)
        IDLE: begin
          if (start) begin
            state <= LOW_CYCLE;
            cnt   <= CW'(FLASH_WAIT - 1);
            armed <= 1'b0;
          end
        end
        LOW_CYCLE: begin
          if (last) begin
            if (split) begin
              state <= HIGH_CYCLE;
              cnt   <= CW'(FLASH_WAIT);  // one extra for the gap
            end else begin
              state <= DONE;
            end
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        HIGH_CYCLE: begin
          if (last)
            state <= DONE;
          else
            cnt <= cnt - 1'b1;
        end
        DONE:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // address and read data path
  always_ff @(posedge cpu_clk) begin
    if (start) begin
      word_q <= rom_addr[16:1];
      odd_q  <= rom_addr[0];
      byte_q <= byte_m;
    end else if (state == LOW_CYCLE && last) begin
      if (byte_q)
        rd_data <= {8'h00, odd_q ? nf_d[15:8] : nf_d[7:0]};
      else if (odd_q) begin
        rd_data[7:0] <= nf_d[15:8];  // upper half comes next cycle
        word_q       <= word_q + 16'd1;
      end else
        rd_data <= nf_d;
    end else if (state == HIGH_CYCLE && last) begin
      rd_data[15:8] <= nf_d[7:0];
    end
  end

  assign nf_a    = FLASH_ROM_BASE + flash_addr_t'(word_q);
  assign nf_ce   = !active;
  assign nf_oe   = !active;
  assign nf_we   = 1'b1;     // read only
  assign nf_byte = 1'b1;     // always word mode
  assign ready   = (state == DONE);

endmodule

//--- verilog/mem_pkg.sv
package mem_pkg;

  // cpu side
  typedef logic [19:0] addr_t;      // real-mode byte address
  typedef logic [15:0] data_t;

  // rom image byte address with bit 16 set for the F segment
  typedef logic [16:0] rom_addr_t;

  // device word addresses
  typedef logic [18:0] word_addr_t;   // 512K words of sram
  typedef logic [20:0] flash_addr_t;  // matches nf_a pins

  typedef struct packed {
    addr_t addr;
    data_t wr_data;
    logic  we;
    logic  byte_m;
  } mem_req_t;

  // one or two device word cycles per access
  typedef enum logic [1:0] {
    IDLE,
    LOW_CYCLE,
    HIGH_CYCLE,
    DONE
  } bus_state_t;

  // top nibble of addr for the rom areas
  localparam logic [3:0] ROM_SEG_BIOS = 4'hf;
  localparam logic [3:0] ROM_SEG_VGA  = 4'hc;

  // where the 128 KB image sits in the flash, in words
  localparam flash_addr_t FLASH_ROM_BASE = 21'h1f_0000;

endpackage
